// ==== hdl/rvPkg.sv ====
//--------------------
// Shared core definitions
// Widths, vector types, FSM state encoding,
// decoded instruction and memory request structs,
// RV32I opcode field values
//--------------------
package rvPkg;

   // Internal address width, used by PC and address adders
   localparam int ADDR_WIDTH = 24;

   typedef logic [31:0]           word_t;
   typedef logic [ADDR_WIDTH-1:0] addr_t;
   typedef logic [4:0]            regIdx_t;
   typedef logic [3:0]            byteMask_t;
   typedef logic [4:0]            shamt_t;
   // Low two bits are always 2'b11 in RV32I, so they are not kept
   typedef logic [31:2]           instrWord_t;

   // First fetch address
   localparam word_t RESET_ADDR = 32'h0000_0000;

   // Opcode field values, instr[6:2]
   localparam logic [4:0] OPC_LOAD   = 5'b00000;
   localparam logic [4:0] OPC_ALUIMM = 5'b00100;
   localparam logic [4:0] OPC_AUIPC  = 5'b00101;
   localparam logic [4:0] OPC_STORE  = 5'b01000;
   localparam logic [4:0] OPC_ALUREG = 5'b01100;
   localparam logic [4:0] OPC_LUI    = 5'b01101;
   localparam logic [4:0] OPC_BRANCH = 5'b11000;
   localparam logic [4:0] OPC_JALR   = 5'b11001;
   localparam logic [4:0] OPC_JAL    = 5'b11011;

   // One-hot sequencer states
   typedef enum logic [4:0] {
      fetchInstr   = 5'b00001,
      waitInstr    = 5'b00010,
      execute1     = 5'b00100,
      execute2     = 5'b01000,
      waitAluOrMem = 5'b10000
   } cpuState_t;

   typedef struct packed {
      logic      isLoad;
      logic      isAluImm;
      logic      isAuipc;
      logic      isStore;
      logic      isAluReg;
      logic      isLui;
      logic      isBranch;
      logic      isJalr;
      logic      isJal;
      logic      isAlu;
      // funct3Is[n] set when funct3 == n
      logic [7:0] funct3Is;
      regIdx_t   rdId;
      logic [1:0] sizeField;
      logic      unsignedLoad;
      logic      subOrSra;
      word_t     iImm;
      word_t     sImm;
      word_t     bImm;
      word_t     uImm;
      word_t     jImm;
   } decodedInstr_t;

   typedef struct packed {
      word_t     addr;
      word_t     wdata;
      byteMask_t wmask;
      logic      rstrb;
   } memReq_t;

endpackage

// ==== hdl/instrDecoder.sv ====
//--------------------
// Instruction decoder
// Opcode flags, one-hot funct3, register index
// and the five immediate formats
//--------------------
`timescale 1ns/10ps

module instrDecoder (
   input  rvPkg::instrWord_t    instr,
   output rvPkg::decodedInstr_t dec
);

   logic [4:0] opcode;

   assign opcode = instr[6:2];

   // Opcode groups, SYSTEM is not decoded
   assign dec.isLoad   = (opcode == rvPkg::OPC_LOAD);
   assign dec.isAluImm = (opcode == rvPkg::OPC_ALUIMM);
   assign dec.isAuipc  = (opcode == rvPkg::OPC_AUIPC);
   assign dec.isStore  = (opcode == rvPkg::OPC_STORE);
   assign dec.isAluReg = (opcode == rvPkg::OPC_ALUREG);
   assign dec.isLui    = (opcode == rvPkg::OPC_LUI);
   assign dec.isBranch = (opcode == rvPkg::OPC_BRANCH);
   assign dec.isJalr   = (opcode == rvPkg::OPC_JALR);
   assign dec.isJal    = (opcode == rvPkg::OPC_JAL);
   assign dec.isAlu    = dec.isAluImm | dec.isAluReg;

   // One-hot funct3 keeps the ALU and predicate muxes flat
   assign dec.funct3Is = 8'b0000_0001 << instr[14:12];

   assign dec.rdId = instr[11:7];

   // Access size: 00 byte, 01 halfword, 10 word
   assign dec.sizeField    = instr[13:12];
   assign dec.unsignedLoad = instr[14];

   // Bit 30 means SUB only in register form, since ADDI reuses it as an immediate bit
   assign dec.subOrSra = instr[30] &
                         ((dec.funct3Is[0] & dec.isAluReg) | dec.funct3Is[5]);

   // Immediates, all sign-extended from bit 31
   assign dec.uImm = {instr[31:12], 12'b0};
   assign dec.iImm = {{21{instr[31]}}, instr[30:20]};
   assign dec.sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
   assign dec.bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
   assign dec.jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

endmodule

// ==== hdl/registerFile.sv ====
//--------------------
// 32-entry register file
// Registered dual read, single write
//--------------------
`timescale 1ns/10ps

module registerFile (
   input  logic           clk,
   input  logic           reset,
   input  rvPkg::regIdx_t rs1Id,
   input  rvPkg::regIdx_t rs2Id,
   input  logic           readEn,
   output rvPkg::word_t   rs1,
   output rvPkg::word_t   rs2,
   input  rvPkg::regIdx_t rdId,
   input  logic           writeEn,
   input  rvPkg::word_t   writeData
);

   rvPkg::word_t regs [32];

   always_ff @(posedge clk) begin
      if (!reset) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
         rs1 <= '0;
         rs2 <= '0;
      end else begin
         // Both operands latched together while the instruction arrives
         if (readEn) begin
            rs1 <= regs[rs1Id];
            rs2 <= regs[rs2Id];
         end
         // x0 stays zero
         if (writeEn && (rdId != 5'd0)) begin
            regs[rdId] <= writeData;
         end
      end
   end

   // Sequencer reads in waitInstr and writes back only in later states
   assert property (@(posedge clk) disable iff (!reset) !(writeEn && readEn))
      else $error("register write and read enable in the same cycle");

endmodule

// ==== hdl/serialAlu.sv ====
//--------------------
// ALU
// Combinational add, subtract and compares,
// branch predicate, registered result
// and one-bit-per-cycle shifter
//--------------------
`timescale 1ns/10ps

module serialAlu (
   input  logic                 clk,
   input  logic                 reset,
   input  rvPkg::decodedInstr_t dec,
   input  rvPkg::word_t         rs1,
   input  rvPkg::word_t         rs2,
   input  logic                 aluWr,
   output rvPkg::word_t         aluPlus,
   output rvPkg::word_t         aluOut,
   output logic                 aluBusy,
   output logic                 predicate
);

   rvPkg::word_t  aluIn2;
   logic [32:0]   aluMinus;
   logic          lt;
   logic          ltu;
   logic          eq;
   logic          isShift;
   rvPkg::word_t  aluReg;
   rvPkg::shamt_t aluShamt;

   // Register operand for ALU-reg and branches, else I immediate
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2 : dec.iImm;

   // Adder also serves JALR target
   assign aluPlus = rs1 + aluIn2;

   // One 33-bit subtract gives SUB and every compare
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, rs1} + 33'd1;
   assign ltu      = aluMinus[32];
   assign lt       = (rs1[31] ^ aluIn2[31]) ? rs1[31] : aluMinus[32];
   assign eq       = (aluMinus[31:0] == 32'd0);

   // BEQ BNE BLT BGE BLTU BGEU
   assign predicate = (dec.funct3Is[0] &  eq)  |
                      (dec.funct3Is[1] & ~eq)  |
                      (dec.funct3Is[4] &  lt)  |
                      (dec.funct3Is[5] & ~lt)  |
                      (dec.funct3Is[6] &  ltu) |
                      (dec.funct3Is[7] & ~ltu);

   assign isShift = dec.funct3Is[1] | dec.funct3Is[5];
   assign aluOut  = aluReg;
   assign aluBusy = |aluShamt;

   always_ff @(posedge clk) begin
      if (!reset) begin
         aluReg   <= '0;
         aluShamt <= '0;
      end else if (aluWr) begin
         // Shifts start from rs1 and count down the amount
         aluShamt <= isShift ? aluIn2[4:0] : 5'd0;
         aluReg   <= (isShift ? rs1 : 32'd0) |
                     (dec.funct3Is[0] ? (dec.subOrSra ? aluMinus[31:0] : aluPlus) : 32'd0) |
                     (dec.funct3Is[2] ? {31'd0, lt}  : 32'd0) |
                     (dec.funct3Is[3] ? {31'd0, ltu} : 32'd0) |
                     (dec.funct3Is[4] ? rs1 ^ aluIn2 : 32'd0) |
                     (dec.funct3Is[6] ? rs1 | aluIn2 : 32'd0) |
                     (dec.funct3Is[7] ? rs1 & aluIn2 : 32'd0);
      end else if (aluBusy) begin
         aluShamt <= aluShamt - 5'd1;
         // SLL left, SRA fills with sign, SRL with zero
         aluReg   <= dec.funct3Is[1] ? {aluReg[30:0], 1'b0} :
                                       {dec.subOrSra & aluReg[31], aluReg[31:1]};
      end
   end

   // Sequencer holds in waitAluOrMem until the shift is done
   assert property (@(posedge clk) disable iff (!reset) !(aluWr && aluBusy))
      else $error("ALU write while a shift is still running");

endmodule

// ==== hdl/loadStoreUnit.sv ====
//--------------------
// Load and store lane logic
// Store data steering and byte mask,
// load extraction with sign or zero extension
//--------------------
`timescale 1ns/10ps

module loadStoreUnit (
   input  rvPkg::decodedInstr_t dec,
   input  logic [1:0]           lowAddr,
   input  rvPkg::word_t         rs2,
   input  rvPkg::word_t         rdata,
   output rvPkg::word_t         storeData,
   output rvPkg::word_t         loadData,
   output rvPkg::byteMask_t     storeMask
);

   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   assign byteAccess = (dec.sizeField == 2'b00);
   assign halfAccess = (dec.sizeField == 2'b01);

   // Byte and halfword copied into every lane that may be addressed
   assign storeData[7:0]   = rs2[7:0];
   assign storeData[15:8]  = lowAddr[0] ? rs2[7:0] : rs2[15:8];
   assign storeData[23:16] = lowAddr[1] ? rs2[7:0] : rs2[23:16];
   assign storeData[31:24] = lowAddr[0] ? rs2[7:0] :
                             lowAddr[1] ? rs2[15:8] : rs2[31:24];

   // Mask picks the lanes actually written
   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << lowAddr;
      end else if (halfAccess) begin
         storeMask = lowAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;
      end
   end

   // Addressed halfword, then the addressed byte within it
   assign loadHalf = lowAddr[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = lowAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // LBU and LHU clear the sign
   assign loadSign = ~dec.unsignedLoad & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

endmodule

// ==== hdl/sequencer.sv ====
//--------------------
// Core sequencer
// One-hot FSM, PC and target adders,
// write-back select and memory request
//--------------------
`timescale 1ns/10ps

module sequencer (
   input  logic                 clk,
   input  logic                 reset,
   input  rvPkg::decodedInstr_t dec,
   input  rvPkg::word_t         rdata,
   input  logic                 rbusy,
   input  logic                 wbusy,
   input  rvPkg::word_t         rs1,
   input  rvPkg::word_t         aluPlus,
   input  rvPkg::word_t         aluOut,
   input  logic                 aluBusy,
   input  logic                 predicate,
   input  rvPkg::word_t         loadData,
   input  rvPkg::word_t         storeData,
   input  rvPkg::byteMask_t     storeMask,
   output rvPkg::instrWord_t    instr,
   output rvPkg::regIdx_t       rs1Id,
   output rvPkg::regIdx_t       rs2Id,
   output logic                 readEn,
   output logic                 writeEn,
   output logic                 aluWr,
   output rvPkg::word_t         writeData,
   output logic [1:0]           lowAddr,
   output rvPkg::memReq_t       memReq
);

   localparam int AW = rvPkg::ADDR_WIDTH;

   rvPkg::cpuState_t state;
   rvPkg::addr_t     pc;
   rvPkg::addr_t     pcPlus4;
   rvPkg::addr_t     pcPlusImm;
   rvPkg::addr_t     lsAddr;
   rvPkg::addr_t     memAddr;
   logic             predicateReg;
   logic             jumpToPcPlusImm;
   logic             needToWait;
   logic             leaveWait;

   assign pcPlus4 = pc + 4;

   // Source indices come straight off the bus while the instruction arrives
   assign rs1Id  = rdata[19:15];
   assign rs2Id  = rdata[24:20];
   assign readEn = (state == rvPkg::waitInstr) & ~rbusy;

   assign aluWr = (state == rvPkg::execute1) & dec.isAlu;

   assign jumpToPcPlusImm = dec.isJal | (dec.isBranch & predicateReg);
   // Stores always wait for wbusy
   assign needToWait      = dec.isLoad | dec.isStore | aluBusy;
   assign leaveWait       = (state == rvPkg::waitAluOrMem) & ~aluBusy & ~rbusy & ~wbusy;

   // Final write happens when the result is ready
   assign writeEn = ~(dec.isBranch | dec.isStore) &
                    (((state == rvPkg::execute2) & ~needToWait) | leaveWait);

   assign writeData = (dec.isLui                ? dec.uImm                  : 32'd0) |
                      (dec.isAlu                ? aluOut                    : 32'd0) |
                      (dec.isAuipc              ? rvPkg::word_t'(pcPlusImm) : 32'd0) |
                      (dec.isJal | dec.isJalr   ? rvPkg::word_t'(pcPlus4)   : 32'd0) |
                      (dec.isLoad               ? loadData                  : 32'd0);

   // PC drives the bus only during fetch
   assign memAddr = ((state == rvPkg::fetchInstr) | (state == rvPkg::waitInstr)) ?
                    pc : lsAddr;
   assign lowAddr = lsAddr[1:0];

   assign memReq.addr  = rvPkg::word_t'(memAddr);
   assign memReq.wdata = storeData;
   assign memReq.wmask = {4{(state == rvPkg::execute2) & dec.isStore}} & storeMask;
   assign memReq.rstrb = ((state == rvPkg::execute2) & dec.isLoad) |
                         (state == rvPkg::fetchInstr);

   always_ff @(posedge clk) begin
      if (!reset) begin
         // Start by waiting for the memory to go idle
         state        <= rvPkg::waitAluOrMem;
         pc           <= rvPkg::RESET_ADDR[AW-1:0];
         // Zero decodes as a load to x0, so nothing gets written
         instr        <= '0;
         predicateReg <= 1'b0;
      end else begin
         case (state)
            rvPkg::fetchInstr: begin
               state <= rvPkg::waitInstr;
            end
            rvPkg::waitInstr: begin
               if (!rbusy) begin
                  instr <= rdata[31:2];
                  state <= rvPkg::execute1;
               end
            end
            rvPkg::execute1: begin
               // Branch, AUIPC and JAL targets share one adder
               pcPlusImm <= pc + (dec.isJal   ? dec.jImm[AW-1:0] :
                                  dec.isAuipc ? dec.uImm[AW-1:0] :
                                                dec.bImm[AW-1:0]);
               lsAddr    <= rs1[AW-1:0] + (dec.isStore ? dec.sImm[AW-1:0] :
                                                         dec.iImm[AW-1:0]);
               predicateReg <= predicate;
               state        <= rvPkg::execute2;
            end
            rvPkg::execute2: begin
               // JALR clears bit 0 of the target
               pc    <= dec.isJalr      ? {aluPlus[AW-1:1], 1'b0} :
                        jumpToPcPlusImm ? pcPlusImm : pcPlus4;
               state <= needToWait ? rvPkg::waitAluOrMem : rvPkg::fetchInstr;
            end
            rvPkg::waitAluOrMem: begin
               if (leaveWait) begin
                  state <= rvPkg::fetchInstr;
               end
            end
            default: begin
               state <= rvPkg::waitAluOrMem;
            end
         endcase
      end
   end

   assert property (@(posedge clk) disable iff (!reset) $onehot(state))
      else $error("sequencer state not one-hot");

   // A read and a write never share the port
   assert property (@(posedge clk) disable iff (!reset) !(memReq.rstrb && (|memReq.wmask)))
      else $error("rstrb and wmask active together");

endmodule

// ==== hdl/tachyonCore.sv ====
//--------------------
// RV32I multi-cycle core top level
// Decoder, register file, ALU,
// load-store unit and sequencer
//--------------------
`timescale 1ns/10ps

module tachyonCore (
   input  logic           clk,
   input  logic           reset,
   output rvPkg::memReq_t memReq,
   input  rvPkg::word_t   rdata,
   input  logic           rbusy,
   input  logic           wbusy
);

   rvPkg::decodedInstr_t dec;
   rvPkg::instrWord_t    instr;
   rvPkg::regIdx_t       rs1Id;
   rvPkg::regIdx_t       rs2Id;
   rvPkg::word_t         rs1;
   rvPkg::word_t         rs2;
   rvPkg::word_t         writeData;
   rvPkg::word_t         aluPlus;
   rvPkg::word_t         aluOut;
   rvPkg::word_t         storeData;
   rvPkg::word_t         loadData;
   rvPkg::byteMask_t     storeMask;
   logic [1:0]           lowAddr;
   logic                 readEn;
   logic                 writeEn;
   logic                 aluWr;
   logic                 aluBusy;
   logic                 predicate;

   instrDecoder decoder0 (
      .instr (instr),
      .dec   (dec)
   );

   registerFile regFile0 (
      .clk       (clk),
      .reset     (reset),
      .rs1Id     (rs1Id),
      .rs2Id     (rs2Id),
      .readEn    (readEn),
      .rs1       (rs1),
      .rs2       (rs2),
      .rdId      (dec.rdId),
      .writeEn   (writeEn),
      .writeData (writeData)
   );

   serialAlu alu0 (
      .clk       (clk),
      .reset     (reset),
      .dec       (dec),
      .rs1       (rs1),
      .rs2       (rs2),
      .aluWr     (aluWr),
      .aluPlus   (aluPlus),
      .aluOut    (aluOut),
      .aluBusy   (aluBusy),
      .predicate (predicate)
   );

   loadStoreUnit lsu0 (
      .dec       (dec),
      .lowAddr   (lowAddr),
      .rs2       (rs2),
      .rdata     (rdata),
      .storeData (storeData),
      .loadData  (loadData),
      .storeMask (storeMask)
   );

   sequencer seq0 (
      .clk       (clk),
      .reset     (reset),
      .dec       (dec),
      .rdata     (rdata),
      .rbusy     (rbusy),
      .wbusy     (wbusy),
      .rs1       (rs1),
      .aluPlus   (aluPlus),
      .aluOut    (aluOut),
      .aluBusy   (aluBusy),
      .predicate (predicate),
      .loadData  (loadData),
      .storeData (storeData),
      .storeMask (storeMask),
      .instr     (instr),
      .rs1Id     (rs1Id),
      .rs2Id     (rs2Id),
      .readEn    (readEn),
      .writeEn   (writeEn),
      .aluWr     (aluWr),
      .writeData (writeData),
      .lowAddr   (lowAddr),
      .memReq    (memReq)
   );

endmodule

// ==== tb/isaModel.svh ====
//--------------------
// RV32I reference model for the testbench
// Memory arrays, program encoders,
// expected store list and the ISA function
//--------------------

typedef struct packed {
   rvPkg::word_t     addr;
   rvPkg::word_t     data;
   rvPkg::byteMask_t mask;
} storeEvent_t;

// jal x0, 0 ends every program
localparam rvPkg::word_t HALT = 32'h0000_006f;

rvPkg::word_t mem [1024];
rvPkg::word_t refMem [1024];
rvPkg::word_t prog [$];
storeEvent_t  expQ [$];

function automatic rvPkg::word_t rType(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
   return {f7, rs2, rs1, f3, rd, rvPkg::OPC_ALUREG, 2'b11};
endfunction

function automatic rvPkg::word_t iType(logic [4:0] opc, logic [11:0] imm, logic [4:0] rs1,
                                       logic [2:0] f3, logic [4:0] rd);
   return {imm, rs1, f3, rd, opc, 2'b11};
endfunction

function automatic rvPkg::word_t sType(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
   return {imm[11:5], rs2, rs1, f3, imm[4:0], rvPkg::OPC_STORE, 2'b11};
endfunction

function automatic rvPkg::word_t bType(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                       logic [2:0] f3);
   return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::OPC_BRANCH, 2'b11};
endfunction

function automatic rvPkg::word_t uType(logic [4:0] opc, logic [19:0] imm, logic [4:0] rd);
   return {imm, rd, opc, 2'b11};
endfunction

function automatic rvPkg::word_t jType(logic [20:0] imm, logic [4:0] rd);
   return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::OPC_JAL, 2'b11};
endfunction

function automatic void emit(rvPkg::word_t w);
   prog.push_back(w);
endfunction

// LUI plus ADDI, upper part rounded for the signed low immediate
function automatic void loadConst(logic [4:0] rd, rvPkg::word_t value);
   rvPkg::word_t upper;
   upper = value + 32'h800;
   emit(uType(rvPkg::OPC_LUI, upper[31:12], rd));
   emit(iType(rvPkg::OPC_ALUIMM, value[11:0], rd, 3'd0, rd));
endfunction

function automatic rvPkg::word_t aluResult(logic [2:0] f3, logic alt, rvPkg::word_t a,
                                           rvPkg::word_t b);
   case (f3)
      3'd0: return alt ? a - b : a + b;
      3'd1: return a << b[4:0];
      3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: return (a < b) ? 32'd1 : 32'd0;
      3'd4: return a ^ b;
      3'd5: return alt ? rvPkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: return a | b;
      default: return a & b;
   endcase
endfunction

function automatic logic branchTaken(logic [2:0] f3, rvPkg::word_t a, rvPkg::word_t b);
   case (f3)
      3'd0: return a == b;
      3'd1: return a != b;
      3'd4: return $signed(a) < $signed(b);
      3'd5: return $signed(a) >= $signed(b);
      3'd6: return a < b;
      default: return a >= b;
   endcase
endfunction

// w already shifted so the addressed byte sits in the low lane
function automatic rvPkg::word_t loadExtend(logic [2:0] f3, rvPkg::word_t w);
   case (f3)
      3'd0: return {{24{w[7]}}, w[7:0]};
      3'd1: return {{16{w[15]}}, w[15:0]};
      3'd4: return {24'd0, w[7:0]};
      3'd5: return {16'd0, w[15:0]};
      default: return w;
   endcase
endfunction

// Runs the program in refMem and lists every store it makes
function automatic void refRun();
   rvPkg::word_t x [32];
   rvPkg::word_t pc;
   rvPkg::word_t ins;
   rvPkg::word_t a;
   rvPkg::word_t b;
   rvPkg::word_t res;
   rvPkg::word_t ea;
   rvPkg::word_t w;
   rvPkg::word_t iImm;
   rvPkg::word_t sImm;
   rvPkg::word_t nextPc;
   storeEvent_t  ev;
   logic [2:0]   f3;
   int           sh;
   x = '{default: '0};
   pc = rvPkg::RESET_ADDR;
   expQ.delete();
   for (int step = 0; step < 4000 && refMem[pc[11:2]] != HALT; step++) begin
      ins    = refMem[pc[11:2]];
      a      = x[ins[19:15]];
      b      = x[ins[24:20]];
      f3     = ins[14:12];
      iImm   = {{20{ins[31]}}, ins[31:20]};
      sImm   = {{20{ins[31]}}, ins[31:25], ins[11:7]};
      ea     = a + ((ins[6:2] == rvPkg::OPC_STORE) ? sImm : iImm);
      sh     = 8 * ea[1:0];
      w      = refMem[ea[11:2]] >> sh;
      nextPc = pc + 4;
      res    = nextPc;
      case (ins[6:2])
         rvPkg::OPC_LUI:    res = {ins[31:12], 12'b0};
         rvPkg::OPC_AUIPC:  res = pc + {ins[31:12], 12'b0};
         rvPkg::OPC_JAL:    nextPc = pc + {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
         rvPkg::OPC_JALR:   nextPc = (a + iImm) & ~32'd1;
         rvPkg::OPC_ALUIMM: res = aluResult(f3, ins[30] & (f3 == 3'd5), a, iImm);
         rvPkg::OPC_ALUREG: res = aluResult(f3, ins[30], a, b);
         rvPkg::OPC_LOAD:   res = loadExtend(f3, w);
         rvPkg::OPC_BRANCH: begin
            if (branchTaken(f3, a, b)) begin
               nextPc = pc + {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            end
         end
         rvPkg::OPC_STORE: begin
            ev.addr = ea;
            ev.mask = (f3 == 3'd0) ? 4'b0001 << ea[1:0] :
                      (f3 == 3'd1) ? 4'b0011 << ea[1:0] : 4'b1111;
            ev.data = (f3 == 3'd0) ? {24'd0, b[7:0]} << sh :
                      (f3 == 3'd1) ? {16'd0, b[15:0]} << sh : b;
            for (int j = 0; j < 4; j++) begin
               if (ev.mask[j]) begin
                  refMem[ea[11:2]][8*j +: 8] = ev.data[8*j +: 8];
               end
            end
            expQ.push_back(ev);
         end
         default: ;
      endcase
      if (ins[6:2] != rvPkg::OPC_BRANCH && ins[6:2] != rvPkg::OPC_STORE && ins[11:7] != 0) begin
         x[ins[11:7]] = res;
      end
      pc = nextPc;
   end
endfunction

// ==== tb/tachyonTb.sv ====
//--------------------
// Testbench for the RV32I core
// Clock, reset, memory with random stalls,
// store monitor, compare tasks, test programs
//--------------------
`timescale 1ns/10ps

module tachyonTb;

   logic           clk = 1'b0;
   logic           reset;
   rvPkg::memReq_t memReq;
   rvPkg::word_t   rdata;
   logic           rbusy;
   logic           wbusy;

   int errors = 0;
   int checks = 0;
   int testsRun = 0;
   int testsFailed = 0;
   int storesSeen = 0;
   int rCnt = 0;
   int wCnt = 0;
   bit inReset = 0;
   bit fetchSeen = 0;

   `include "isaModel.svh"

   tachyonCore dut0 (
      .clk    (clk),
      .reset  (reset),
      .memReq (memReq),
      .rdata  (rdata),
      .rbusy  (rbusy),
      .wbusy  (wbusy)
   );

   always #20 clk = ~clk;

   task automatic checkWord(input string what, input rvPkg::word_t got, input rvPkg::word_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic checkMask(input string what, input rvPkg::byteMask_t got,
                            input rvPkg::byteMask_t exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
      end
   endtask

   // Memory responder and store monitor
   always @(posedge clk) begin
      storeEvent_t  ev;
      rvPkg::word_t laneBits;
      if (!reset) begin
         // Outputs only settle after the first edge with reset low
         if (inReset && (memReq.rstrb || memReq.wmask != 4'd0)) begin
            errors++;
            $display("[FAIL] %0t memory request during reset", $time);
         end
         inReset = 1;
         fetchSeen = 0;
         storesSeen = 0;
         rCnt = 0;
         wCnt = 0;
         rbusy <= 1'b0;
         wbusy <= 1'b0;
      end else begin
         inReset = 0;
         if (memReq.rstrb) begin
            if (!fetchSeen) begin
               checkWord("first fetch address", memReq.addr, rvPkg::RESET_ADDR);
               fetchSeen = 1;
            end
            rdata <= mem[memReq.addr[11:2]];
            rCnt = $urandom_range(3, 0);
         end else if (rCnt > 0) begin
            rCnt--;
         end
         rbusy <= (rCnt != 0);
         if (memReq.wmask != 4'd0) begin
            laneBits = {{8{memReq.wmask[3]}}, {8{memReq.wmask[2]}},
                        {8{memReq.wmask[1]}}, {8{memReq.wmask[0]}}};
            for (int j = 0; j < 4; j++) begin
               if (memReq.wmask[j]) begin
                  mem[memReq.addr[11:2]][8*j +: 8] = memReq.wdata[8*j +: 8];
               end
            end
            if (expQ.size() == 0) begin
               errors++;
               $display("Store to %h was not expected by the reference", memReq.addr);
            end else begin
               ev = expQ.pop_front();
               checkWord("store address", memReq.addr, ev.addr);
               checkWord("store data", memReq.wdata & laneBits, ev.data);
               checkMask("store mask", memReq.wmask, ev.mask);
            end
            storesSeen++;
            wCnt = $urandom_range(3, 0);
         end else if (wCnt > 0) begin
            wCnt--;
         end
         wbusy <= (wCnt != 0);
      end
   end

   // Loads the program, runs the reference, then the DUT from reset
   task automatic runTest(input string name);
      int errBefore;
      int cyc;
      int expCount;
      errBefore = errors;
      @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      for (int i = 0; i < 1024; i++) begin
         mem[i] = {i[15:0] ^ 16'h5a3c, ~i[15:0]};
      end
      prog.push_back(HALT);
      foreach (prog[i]) begin
         mem[i] = prog[i];
      end
      refMem = mem;
      refRun();
      expCount = expQ.size();
      prog.delete();
      repeat (3) @(posedge clk);
      reset <= 1'b1;
      cyc = 0;
      while (storesSeen < expCount && cyc < 20000) begin
         @(posedge clk);
         cyc++;
      end
      testsRun++;
      if (storesSeen < expCount) begin
         errors++;
         testsFailed++;
         $display("Timeout in %s: %0d of %0d stores seen", name, storesSeen, expCount);
      end else begin
         @(posedge clk);
         if (errors == errBefore) begin
            $display("%s: ok, %0d stores", name, expCount);
         end else begin
            testsFailed++;
            $display("%s: FAILED with %0d errors", name, errors - errBefore);
         end
      end
   endtask

   task automatic buildResetTest();
      loadConst(31, 32'h800);
      emit(iType(rvPkg::OPC_ALUIMM, 12'h5a5, 0, 3'd0, 1));
      emit(sType(12'd0, 1, 31, 3'd2));
   endtask

   task automatic buildAluTest();
      logic [2:0]   regF3 [7] = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
      logic [2:0]   immF3 [6] = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
      rvPkg::word_t a;
      rvPkg::word_t b;
      loadConst(31, 32'h800);
      for (int k = 0; k < 13; k++) begin
         a = $urandom;
         b = $urandom;
         loadConst(1, a);
         loadConst(2, b);
         if (k < 7) begin
            emit(rType((k == 1) ? 7'h20 : 7'h00, 2, 1, regF3[k], 3));
         end else begin
            emit(iType(rvPkg::OPC_ALUIMM, b[11:0], 1, immF3[k-7], 3));
         end
         emit(sType(12'(4*k), 3, 31, 3'd2));
      end
      // x0 must still read zero
      emit(iType(rvPkg::OPC_ALUIMM, 12'h07b, 0, 3'd0, 0));
      emit(sType(12'd52, 0, 31, 3'd2));
   endtask

   task automatic buildShiftTest();
      rvPkg::word_t b;
      logic [2:0]   f3;
      logic [6:0]   f7;
      loadConst(31, 32'h800);
      for (int k = 0; k < 12; k++) begin
         b = $urandom;
         f3 = ((k % 3) == 0) ? 3'd1 : 3'd5;
         f7 = ((k % 3) == 2) ? 7'h20 : 7'h00;
         loadConst(1, $urandom);
         loadConst(2, b);
         if ((k % 6) < 3) begin
            emit(rType(f7, 2, 1, f3, 3));
         end else begin
            emit(iType(rvPkg::OPC_ALUIMM, {f7, b[4:0]}, 1, f3, 3));
         end
         emit(sType(12'(4*k), 3, 31, 3'd2));
      end
   endtask

   task automatic buildControlTest();
      logic [2:0]   brF3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
      rvPkg::word_t a;
      rvPkg::word_t b;
      loadConst(31, 32'h800);
      for (int k = 0; k < 6; k++) begin
         a = $urandom;
         b = $urandom_range(1, 0) ? a : $urandom;
         loadConst(1, a);
         loadConst(2, b);
         emit(iType(rvPkg::OPC_ALUIMM, 12'd1, 0, 3'd0, 5));
         emit(bType(13'd8, 2, 1, brF3[k]));
         emit(iType(rvPkg::OPC_ALUIMM, 12'd2, 0, 3'd0, 5));
         emit(sType(12'(4*k), 5, 31, 3'd2));
      end
      // JAL skips one instruction
      emit(jType(21'd8, 6));
      emit(iType(rvPkg::OPC_ALUIMM, 12'd7, 0, 3'd0, 12));
      emit(sType(12'd24, 6, 31, 3'd2));
      emit(sType(12'd28, 12, 31, 3'd2));
      // JALR lands 12 bytes past the AUIPC
      emit(uType(rvPkg::OPC_AUIPC, 20'd0, 8));
      emit(iType(rvPkg::OPC_JALR, 12'd12, 8, 3'd0, 9));
      emit(iType(rvPkg::OPC_ALUIMM, 12'd1, 0, 3'd0, 10));
      emit(sType(12'd32, 9, 31, 3'd2));
      emit(sType(12'd36, 8, 31, 3'd2));
      emit(sType(12'd40, 10, 31, 3'd2));
      a = $urandom;
      emit(uType(rvPkg::OPC_LUI, a[31:12], 11));
      emit(sType(12'd44, 11, 31, 3'd2));
      emit(uType(rvPkg::OPC_AUIPC, 20'h00012, 13));
      emit(sType(12'd48, 13, 31, 3'd2));
   endtask

   task automatic buildLaneTest();
      int slot;
      slot = 16;
      loadConst(31, 32'h800);
      for (int off = 0; off < 4; off++) begin
         loadConst(1, $urandom);
         emit(sType(12'(off), 1, 31, 3'd0));
      end
      for (int off = 0; off < 4; off += 2) begin
         loadConst(1, $urandom);
         emit(sType(12'(4 + off), 1, 31, 3'd1));
      end
      // LB then LBU of each byte, LH then LHU of each half, then LW
      for (int u = 0; u < 2; u++) begin
         for (int off = 0; off < 4; off++) begin
            emit(iType(rvPkg::OPC_LOAD, 12'(off), 31, (u == 1) ? 3'd4 : 3'd0, 2));
            emit(sType(12'(slot), 2, 31, 3'd2));
            slot += 4;
         end
         for (int off = 0; off < 4; off += 2) begin
            emit(iType(rvPkg::OPC_LOAD, 12'(4 + off), 31, (u == 1) ? 3'd5 : 3'd1, 2));
            emit(sType(12'(slot), 2, 31, 3'd2));
            slot += 4;
         end
      end
      emit(iType(rvPkg::OPC_LOAD, 12'd0, 31, 3'd2, 2));
      emit(sType(12'(slot), 2, 31, 3'd2));
   endtask

   initial begin
      int seedDummy;
      reset = 1'b0;
      rdata = '0;
      rbusy = 1'b0;
      wbusy = 1'b0;
      seedDummy = $urandom(32'hd87e);
      buildResetTest();
      runTest("reset and first fetch");
      buildAluTest();
      runTest("ALU immediate and register");
      buildShiftTest();
      runTest("shifts");
      buildControlTest();
      runTest("branches, jumps, LUI, AUIPC");
      buildLaneTest();
      runTest("byte and halfword lanes");
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               testsRun, testsFailed, checks, errors);
      if (errors == 0 && testsFailed == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule

// ==== verilog.f ====
+incdir+tb
hdl/rvPkg.sv
hdl/instrDecoder.sv
hdl/registerFile.sv
hdl/serialAlu.sv
hdl/loadStoreUnit.sv
hdl/sequencer.sv
hdl/tachyonCore.sv
tb/tachyonTb.sv
